//--- tb.f
design/fft_types_pkg.sv
design/twiddle_cfg_pkg.sv
design/twiddle_phase_divider.sv
design/twiddle_cordic.sv
design/twiddle_power_gen.sv
design/sample_delay_line.sv
design/cpx_twiddle_mult.sv
design/twiddle_round_out.sv
design/twiddle_stage_top.sv
bench/twiddle_stage_assertions.sv
bench/twiddle_stage_tb.sv

//--- bench/twiddle_stage_tb.sv
`timescale 1ns/1ps

module twiddle_stage_tb import fft_types_pkg::*, twiddle_cfg_pkg::*;;

	logic clk;
	logic rst_n;
	logic in_val;
	sample_group_t din;
	tw_ratio_t tw_num;
	tw_ratio_t tw_den;
	radix_t factor;
	logic out_val;
	sample_group_t dout;

	integer seed;
	int assert_errors;
	int timeout_errors;
	int sent_count;
	int out_count;

	twiddle_stage_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_val(in_val),
		.din(din),
		.tw_num(tw_num),
		.tw_den(tw_den),
		.factor(factor),
		.out_val(out_val),
		.dout(dout)
	);

	bind twiddle_stage_top twiddle_stage_assertions u_assertions (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (rst_n && out_val) begin
			out_count <= out_count + 1;
		end
	end

	// small values keep twiddle error inside the 8 lsb window
	function automatic sample_t rand_comp(input bit full_scale);
		if (full_scale) begin
			return sample_t'($random(seed));
		end
		return sample_t'($random(seed) % 2048);
	endfunction

	function automatic sample_group_t rand_group(input bit full_scale);
		sample_group_t g;
		for (int k = 0; k < LANES; k++) begin
			g[k].re = rand_comp(full_scale);
			g[k].im = rand_comp(full_scale);
		end
		return g;
	endfunction

	task automatic drive_group(input sample_group_t g, input tw_ratio_t n, input tw_ratio_t d,
			input radix_t f);
		@(posedge clk);
		in_val <= 1'b1;
		din <= g;
		tw_num <= n;
		tw_den <= d;
		factor <= f;
		sent_count++;
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			in_val <= 1'b0;
			din <= '0;
		end
	endtask

	task automatic random_gap();
		if (($random(seed) & 3) == 0) begin
			drive_idle(1 + $unsigned($random(seed)) % 3);
		end
	endtask

	task automatic wait_for_outputs(input int limit);
		int cycles;
		cycles = 0;
		while (out_count != sent_count && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (out_count != sent_count) begin
			timeout_errors++;
			$display("timeout: only %0d of %0d groups came out", out_count, sent_count);
		end
	endtask

	initial begin
		sample_group_t g;
		tw_ratio_t n;
		tw_ratio_t d;
		seed = 32'ha09a;
		clk = 1'b0;
		rst_n = 1'b0;
		in_val = 1'b0;
		din = '0;
		tw_num = '0;
		tw_den = tw_ratio_t'(1);
		factor = '0;
		assert_errors = 0;
		timeout_errors = 0;
		sent_count = 0;
		out_count = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		drive_idle(5);
		// d = 1, exact unity on every lane
		for (int i = 0; i < 16; i++) begin
			drive_group(rand_group(1'b1), '0, tw_ratio_t'(1), radix_t'($random(seed)));
		end
		drive_idle(3);
		// radix 2, small angle, lanes 1 and 3 equal
		for (int i = 0; i < 12; i++) begin
			g = rand_group(1'b0);
			g[3] = g[1];
			d = tw_ratio_t'(8 + $unsigned($random(seed)) % 57);
			n = tw_ratio_t'(1 + $unsigned($random(seed)) % 3);
			drive_group(g, n, d, radix_t'(2));
			random_gap();
		end
		// any n below d
		for (int i = 0; i < 60; i++) begin
			d = tw_ratio_t'(2 + $unsigned($random(seed)) % 4094);
			n = tw_ratio_t'($unsigned($random(seed)) % d);
			drive_group(rand_group(1'b0), n, d, radix_t'($random(seed)));
			random_gap();
		end
		// back to back burst
		for (int i = 0; i < 10; i++) begin
			if (i % 2 == 1) begin
				drive_group(rand_group(1'b1), '0, tw_ratio_t'(1), radix_t'(4));
			end else begin
				drive_group(rand_group(1'b0), tw_ratio_t'(i + 1), tw_ratio_t'(37), radix_t'(5));
			end
		end
		drive_idle(1);
		wait_for_outputs(STAGE_LAT + 10);
		drive_idle(5);
		$display("assertion errors: %0d, wait timeouts: %0d", assert_errors, timeout_errors);
		if (assert_errors == 0 && timeout_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- bench/twiddle_stage_assertions.sv
`timescale 1ns/1ps

module twiddle_stage_assertions import fft_types_pkg::*, twiddle_cfg_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_val,
	input sample_group_t din,
	input tw_ratio_t tw_num,
	input tw_ratio_t tw_den,
	input radix_t factor,
	input logic out_val,
	input sample_group_t dout
);

	// entry STAGE_LAT-1 holds the inputs of the group now leaving
	logic [STAGE_LAT-1:0] val_hist;
	sample_group_t din_hist [STAGE_LAT];
	tw_ratio_t num_hist [STAGE_LAT];
	tw_ratio_t den_hist [STAGE_LAT];
	radix_t fac_hist [STAGE_LAT];

	sample_group_t x_old;
	tw_ratio_t n_old;
	tw_ratio_t d_old;
	radix_t f_old;

	assign x_old = din_hist[STAGE_LAT-1];
	assign n_old = num_hist[STAGE_LAT-1];
	assign d_old = den_hist[STAGE_LAT-1];
	assign f_old = fac_hist[STAGE_LAT-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_hist <= '0;
		end else begin
			val_hist <= {val_hist[STAGE_LAT-2:0], in_val};
		end
	end

	always_ff @(posedge clk) begin
		din_hist[0] <= din;
		num_hist[0] <= tw_num;
		den_hist[0] <= tw_den;
		fac_hist[0] <= factor;
		for (int i = 1; i < STAGE_LAT; i++) begin
			din_hist[i] <= din_hist[i-1];
			num_hist[i] <= num_hist[i-1];
			den_hist[i] <= den_hist[i-1];
			fac_hist[i] <= fac_hist[i-1];
		end
	end

	// ideal rotation by -2pi*p*n/d, p follows the radix 2 lane pattern
	function automatic bit rotation_ok(input sample_group_t x, input sample_group_t y,
			input tw_ratio_t n, input tw_ratio_t d, input radix_t f);
		real two_pi;
		real ang;
		real c;
		real s;
		real ref_re;
		real ref_im;
		int p;
		two_pi = 8.0 * $atan(1.0);
		for (int k = 1; k < LANES; k++) begin
			p = (f == radix_t'(2)) ? k % 2 : k;
			ang = -two_pi * real'(p) * real'(n) / real'(d);
			c = $cos(ang);
			s = $sin(ang);
			ref_re = real'(x[k].re) * c - real'(x[k].im) * s;
			ref_im = real'(x[k].re) * s + real'(x[k].im) * c;
			if (real'(y[k].re) - ref_re > 8.0 || ref_re - real'(y[k].re) > 8.0) begin
				return 1'b0;
			end
			if (real'(y[k].im) - ref_im > 8.0 || ref_im - real'(y[k].im) > 8.0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	a_val_timing: assert property (@(posedge clk) disable iff (!rst_n)
		out_val == val_hist[STAGE_LAT-1])
		else begin
			twiddle_stage_tb.assert_errors = twiddle_stage_tb.assert_errors + 1;
			$error("Fail %0t: out_val not aligned with in_val", $time);
		end

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_val |-> dout == '0)
		else begin
			twiddle_stage_tb.assert_errors = twiddle_stage_tb.assert_errors + 1;
			$error("Fail %0t: dout not zero while idle", $time);
		end

	a_lane0: assert property (@(posedge clk) disable iff (!rst_n)
		out_val |-> dout[0] == x_old[0])
		else begin
			twiddle_stage_tb.assert_errors = twiddle_stage_tb.assert_errors + 1;
			$error("Fail %0t: lane 0 changed", $time);
		end

	a_unity: assert property (@(posedge clk) disable iff (!rst_n)
		out_val && d_old == tw_ratio_t'(1) |-> dout == x_old)
		else begin
			twiddle_stage_tb.assert_errors = twiddle_stage_tb.assert_errors + 1;
			$error("Fail %0t: unity twiddle altered a lane", $time);
		end

	// lanes 2 and 4 pass through, lane 3 turns like lane 1
	a_radix2: assert property (@(posedge clk) disable iff (!rst_n)
		out_val && f_old == radix_t'(2) |-> dout[2] == x_old[2] && dout[4] == x_old[4]
			&& (x_old[1] != x_old[3] || dout[3] == dout[1]))
		else begin
			twiddle_stage_tb.assert_errors = twiddle_stage_tb.assert_errors + 1;
			$error("Fail %0t: radix 2 lane pattern wrong", $time);
		end

	a_rotation: assert property (@(posedge clk) disable iff (!rst_n)
		out_val |-> rotation_ok(x_old, dout, n_old, d_old, f_old))
		else begin
			twiddle_stage_tb.assert_errors = twiddle_stage_tb.assert_errors + 1;
			$error("Fail %0t: rotated lane off by more than 8 lsb", $time);
		end

endmodule

//--- design/twiddle_stage_top.sv
`timescale 1ns/1ps

module twiddle_stage_top import fft_types_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_val,
	input sample_group_t din,
	input tw_ratio_t tw_num,
	input tw_ratio_t tw_den,
	input radix_t factor,
	output logic out_val,
	output sample_group_t dout
);

	phase_t div_phase;
	radix_t div_factor;
	radix_t cordic_factor;
	cpx_twiddle_t cordic_w;
	twiddle_group_t twiddles;
	sample_group_t din_dly;
	logic val_dly;
	product_group_t prod;
	cpx_sample_t lane0;
	logic prod_val;

	// decode, n/d to unit twiddle w
	twiddle_phase_divider u_divider (
		.clk(clk),
		.rst_n(rst_n),
		.in_val(in_val),
		.num(tw_num),
		.den(tw_den),
		.factor_in(factor),
		.phase(div_phase),
		.factor_out(div_factor)
	);

	twiddle_cordic u_cordic (
		.clk(clk),
		.phase(div_phase),
		.factor_in(div_factor),
		.w(cordic_w),
		.factor_out(cordic_factor)
	);

	// execute, powers of w meet the delayed samples
	twiddle_power_gen u_power (
		.clk(clk),
		.w(cordic_w),
		.factor(cordic_factor),
		.twiddles(twiddles)
	);

	sample_delay_line u_delay (
		.clk(clk),
		.rst_n(rst_n),
		.din(din),
		.in_val(in_val),
		.din_dly(din_dly),
		.val_dly(val_dly)
	);

	cpx_twiddle_mult u_mult (
		.clk(clk),
		.rst_n(rst_n),
		.din(din_dly),
		.val(val_dly),
		.twiddles(twiddles),
		.prod(prod),
		.lane0(lane0),
		.prod_val(prod_val)
	);

	// result
	twiddle_round_out u_round (
		.clk(clk),
		.rst_n(rst_n),
		.prod(prod),
		.lane0(lane0),
		.prod_val(prod_val),
		.dout(dout),
		.out_val(out_val)
	);

endmodule

//--- design/twiddle_round_out.sv
`timescale 1ns/1ps

module twiddle_round_out import fft_types_pkg::*, twiddle_cfg_pkg::*; (
	input logic clk,
	input logic rst_n,
	input product_group_t prod,
	input cpx_sample_t lane0,
	input logic prod_val,
	output sample_group_t dout,
	output logic out_val
);

	sample_group_t dout_next;

	// keep 1.17 out of 3.31 and round half up on the first dropped bit
	function automatic sample_t round_prod(input product_t p);
		return p[TW_FRAC+$bits(sample_t)-1:TW_FRAC] + sample_t'(p[TW_FRAC-1]);
	endfunction

	always_comb begin
		dout_next[0] = lane0;
		for (int k = 1; k < LANES; k++) begin
			dout_next[k].re = round_prod(prod.re[k]);
			dout_next[k].im = round_prod(prod.im[k]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val <= 1'b0;
		end else begin
			out_val <= prod_val;
		end
	end

	// dout reads zero whenever out_val is low
	always_ff @(posedge clk) begin
		dout <= prod_val ? dout_next : '0;
	end

endmodule

//--- design/cpx_twiddle_mult.sv
`timescale 1ns/1ps

module cpx_twiddle_mult import fft_types_pkg::*, twiddle_cfg_pkg::*; (
	input logic clk,
	input logic rst_n,
	input sample_group_t din,
	input logic val,
	input twiddle_group_t twiddles,
	output product_group_t prod,
	output cpx_sample_t lane0,
	output logic prod_val
);

	// partial products of (a + jb)(c + jd)
	product_t pp_ac [1:LANES-1];
	product_t pp_bd [1:LANES-1];
	product_t pp_ad [1:LANES-1];
	product_t pp_bc [1:LANES-1];
	cpx_sample_t lane0_d1;
	logic val_d1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_d1 <= 1'b0;
			prod_val <= 1'b0;
		end else begin
			val_d1 <= val;
			prod_val <= val_d1;
		end
	end

	// stage 1, idle cycles carry zeros
	always_ff @(posedge clk) begin
		for (int k = 1; k < LANES; k++) begin
			if (val) begin
				pp_ac[k] <= din[k].re * twiddles[k].re;
				pp_bd[k] <= din[k].im * twiddles[k].im;
				pp_ad[k] <= din[k].re * twiddles[k].im;
				pp_bc[k] <= din[k].im * twiddles[k].re;
			end else begin
				pp_ac[k] <= '0;
				pp_bd[k] <= '0;
				pp_ad[k] <= '0;
				pp_bc[k] <= '0;
			end
		end
		lane0_d1 <= val ? din[0] : '0;
	end

	// stage 2, combine into re and im
	always_ff @(posedge clk) begin
		for (int k = 1; k < LANES; k++) begin
			prod.re[k] <= pp_ac[k] - pp_bd[k];
			prod.im[k] <= pp_ad[k] + pp_bc[k];
		end
		lane0 <= lane0_d1;
	end

endmodule

//--- design/sample_delay_line.sv
`timescale 1ns/1ps

module sample_delay_line import fft_types_pkg::*, twiddle_cfg_pkg::*; (
	input logic clk,
	input logic rst_n,
	input sample_group_t din,
	input logic in_val,
	output sample_group_t din_dly,
	output logic val_dly
);

	// depth matches divider, CORDIC and power generation together
	sample_group_t data_q [TW_LAT];
	logic [TW_LAT-1:0] val_q;

	always_ff @(posedge clk) begin
		data_q[0] <= din;
		for (int i = 1; i < TW_LAT; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q <= '0;
		end else begin
			val_q <= {val_q[TW_LAT-2:0], in_val};
		end
	end

	assign din_dly = data_q[TW_LAT-1];
	assign val_dly = val_q[TW_LAT-1];

endmodule

//--- design/twiddle_power_gen.sv
`timescale 1ns/1ps

module twiddle_power_gen import fft_types_pkg::*, twiddle_cfg_pkg::*; (
	input logic clk,
	input cpx_twiddle_t w,
	input radix_t factor,
	output twiddle_group_t twiddles
);

	typedef logic signed [31:0] tw_prod_t;

	tw_prod_t sq_rr, sq_ii, sq_ri;
	tw_prod_t c_rr, c_ii, c_ri, c_ir;
	tw_prod_t q_rr, q_ii, q_ri;
	cpx_twiddle_t w_d1, w_d2, w2, w2_d2, w3, w4;
	cpx_twiddle_t tw_one;
	radix_t fac_d1, fac_d2;

	// 4.28 back to 2.14, truncating
	function automatic twiddle_t tw_trunc(input tw_prod_t p);
		return p[TW_FRAC+15:TW_FRAC];
	endfunction

	assign tw_one = '{re: twiddle_t'(1 << TW_FRAC), im: '0};

	// stage 1, w squared
	always_ff @(posedge clk) begin
		sq_rr <= w.re * w.re;
		sq_ii <= w.im * w.im;
		sq_ri <= w.re * w.im;
		w_d1 <= w;
		fac_d1 <= factor;
	end

	assign w2.re = tw_trunc(sq_rr - sq_ii);
	assign w2.im = tw_trunc(sq_ri <<< 1);

	// stage 2, w3 from w and w2, w4 from w2 squared
	always_ff @(posedge clk) begin
		c_rr <= w_d1.re * w2.re;
		c_ii <= w_d1.im * w2.im;
		c_ri <= w_d1.re * w2.im;
		c_ir <= w_d1.im * w2.re;
		q_rr <= w2.re * w2.re;
		q_ii <= w2.im * w2.im;
		q_ri <= w2.re * w2.im;
		w_d2 <= w_d1;
		w2_d2 <= w2;
		fac_d2 <= fac_d1;
	end

	assign w3.re = tw_trunc(c_rr - c_ii);
	assign w3.im = tw_trunc(c_ri + c_ir);
	assign w4.re = tw_trunc(q_rr - q_ii);
	assign w4.im = tw_trunc(q_ri <<< 1);

	// stage 3, lane pattern
	always_ff @(posedge clk) begin
		twiddles[1] <= w_d2;
		if (fac_d2 == radix_t'(2)) begin
			// radix 2 alternates w and unity
			twiddles[2] <= tw_one;
			twiddles[3] <= w_d2;
			twiddles[4] <= tw_one;
		end else begin
			twiddles[2] <= w2_d2;
			twiddles[3] <= w3;
			twiddles[4] <= w4;
		end
	end

endmodule

//--- design/twiddle_cordic.sv
`timescale 1ns/1ps

module twiddle_cordic import fft_types_pkg::*, twiddle_cfg_pkg::*; (
	input logic clk,
	input phase_t phase,
	input radix_t factor_in,
	output cpx_twiddle_t w,
	output radix_t factor_out
);

	// 2.18 inside, four guard bits below the twiddle lsb
	typedef logic signed [19:0] cordic_xy_t;
	typedef logic signed [17:0] cordic_z_t;

	cordic_xy_t x_q [CORDIC_ITERS+1];
	cordic_xy_t y_q [CORDIC_ITERS+1];
	cordic_z_t z_q [CORDIC_ITERS+1];
	logic [1:0] quad_q [CORDIC_ITERS+1];
	logic zero_q [CORDIC_ITERS+1];
	radix_t fac_q [CORDIC_ITERS+1];

	cordic_xy_t x_rnd;
	cordic_xy_t y_rnd;
	twiddle_t c;
	twiddle_t s;
	twiddle_t cos_v;
	twiddle_t sin_v;

	// fold into the first quadrant
	always_ff @(posedge clk) begin
		x_q[0] <= cordic_xy_t'(CORDIC_GAIN_COMP) <<< 4;
		y_q[0] <= '0;
		z_q[0] <= cordic_z_t'({4'b0000, phase[13:0]});
		quad_q[0] <= phase[15:14];
		zero_q[0] <= (phase == '0);
		fac_q[0] <= factor_in;
	end

	for (genvar i = 0; i < CORDIC_ITERS; i++) begin : g_iter
		always_ff @(posedge clk) begin
			// rotate toward zero residual angle
			if (z_q[i] >= 0) begin
				x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
				y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
				z_q[i+1] <= z_q[i] - cordic_z_t'(CORDIC_ATAN[i]);
			end else begin
				x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
				y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
				z_q[i+1] <= z_q[i] + cordic_z_t'(CORDIC_ATAN[i]);
			end
			quad_q[i+1] <= quad_q[i];
			zero_q[i+1] <= zero_q[i];
			fac_q[i+1] <= fac_q[i];
		end
	end

	// drop guard bits with rounding
	assign x_rnd = x_q[CORDIC_ITERS] + cordic_xy_t'(8);
	assign y_rnd = y_q[CORDIC_ITERS] + cordic_xy_t'(8);
	assign c = x_rnd[19:4];
	assign s = y_rnd[19:4];

	// undo the fold with sign and swap
	always_comb begin
		unique case (quad_q[CORDIC_ITERS])
			2'd0: begin
				cos_v = c;
				sin_v = s;
			end
			2'd1: begin
				cos_v = -s;
				sin_v = c;
			end
			2'd2: begin
				cos_v = -c;
				sin_v = -s;
			end
			default: begin
				cos_v = s;
				sin_v = -c;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		// exact unity keeps d = 1 lossless
		if (zero_q[CORDIC_ITERS]) begin
			w.re <= twiddle_t'(1 << TW_FRAC);
			w.im <= '0;
		end else begin
			// forward transform, exp(-j phi)
			w.re <= cos_v;
			w.im <= -sin_v;
		end
		factor_out <= fac_q[CORDIC_ITERS];
	end

endmodule

//--- design/twiddle_phase_divider.sv
`timescale 1ns/1ps

module twiddle_phase_divider import fft_types_pkg::*, twiddle_cfg_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_val,
	input tw_ratio_t num,
	input tw_ratio_t den,
	input radix_t factor_in,
	output phase_t phase,
	output radix_t factor_out
);

	tw_ratio_t rem_q [DIV_LAT];
	tw_ratio_t den_q [DIV_LAT];
	phase_t quo_q [DIV_LAT];
	radix_t fac_q [DIV_LAT];
	// stage s holds a live group while val_q[s] is set
	logic [DIV_LAT-2:0] val_q;

	// one restoring step, returns {quotient bit, next remainder}
	function automatic logic [12:0] div_step(input tw_ratio_t rem, input tw_ratio_t dv);
		logic [12:0] trial;
		trial = {rem, 1'b0};
		if (trial >= {1'b0, dv}) begin
			return {1'b1, tw_ratio_t'(trial - {1'b0, dv})};
		end
		return {1'b0, trial[11:0]};
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q <= '0;
		end else begin
			val_q <= {val_q[DIV_LAT-3:0], in_val};
		end
	end

	// head stage settles the top five bits, later stages one bit each
	always_ff @(posedge clk) begin
		tw_ratio_t rem;
		phase_t quo;
		logic [12:0] step;
		rem = num;
		quo = '0;
		for (int b = $bits(phase_t) - 1; b >= DIV_LAT - 1; b--) begin
			step = div_step(rem, den);
			quo[b] = step[12];
			rem = step[11:0];
		end
		if (in_val) begin
			rem_q[0] <= rem;
			quo_q[0] <= quo;
			den_q[0] <= den;
			fac_q[0] <= factor_in;
		end
	end

	for (genvar s = 1; s < DIV_LAT; s++) begin : g_stage
		logic [12:0] step;
		assign step = div_step(rem_q[s-1], den_q[s-1]);

		always_ff @(posedge clk) begin
			if (val_q[s-1]) begin
				rem_q[s] <= step[11:0];
				den_q[s] <= den_q[s-1];
				quo_q[s] <= quo_q[s-1] | (phase_t'(step[12]) << (DIV_LAT - 1 - s));
				fac_q[s] <= fac_q[s-1];
			end
		end
	end

	assign phase = quo_q[DIV_LAT-1];
	assign factor_out = fac_q[DIV_LAT-1];

endmodule

//--- design/twiddle_cfg_pkg.sv
package twiddle_cfg_pkg;
	import fft_types_pkg::*;

	localparam int LANES = 5;
	localparam int TW_FRAC = 14;

	localparam int DIV_LAT = 12;
	localparam int CORDIC_ITERS = 14;
	// quadrant fold, micro-rotations, output register
	localparam int CORDIC_LAT = CORDIC_ITERS + 2;
	localparam int POWER_LAT = 3;
	localparam int TW_LAT = DIV_LAT + CORDIC_LAT + POWER_LAT;
	localparam int MULT_LAT = 2;
	// plus one cycle for rounding
	localparam int STAGE_LAT = TW_LAT + MULT_LAT + 1;

	// atan(2^-i) in units of 2^-16 turn
	localparam phase_t CORDIC_ATAN [CORDIC_ITERS] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297, 16'd651, 16'd326, 16'd163,
		16'd81, 16'd41, 16'd20, 16'd10, 16'd5, 16'd3, 16'd1
	};

	// 16384 / 1.647, start vector shrunk by the CORDIC gain
	localparam twiddle_t CORDIC_GAIN_COMP = 16'sd9948;

endpackage

//--- design/fft_types_pkg.sv
package fft_types_pkg;

	// sample component, 1.17
	typedef logic signed [17:0] sample_t;

	// twiddle component, 2.14 with unity at 16384
	typedef logic signed [15:0] twiddle_t;

	// sample times twiddle, 3.31
	typedef logic signed [33:0] product_t;

	// fraction of one full turn
	typedef logic [15:0] phase_t;

	typedef logic [11:0] tw_ratio_t;
	typedef logic [2:0] radix_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cpx_sample_t;

	typedef struct packed {
		twiddle_t re;
		twiddle_t im;
	} cpx_twiddle_t;

	// lanes 0 to 4
	typedef cpx_sample_t [4:0] sample_group_t;

	// lane 0 is never rotated, so only lanes 1 to 4
	typedef cpx_twiddle_t [4:1] twiddle_group_t;

	typedef struct packed {
		product_t [4:1] re;
		product_t [4:1] im;
	} product_group_t;

endpackage
